/* fe_macros.svh */
// sizes are fixed for RV32 without compressed instructions; the table index must fit below bit 32
`ifndef FE_MACROS_SVH
`define FE_MACROS_SVH

// ------------------------------
// datapath widths
// ------------------------------

// fetch address width, RV32 only
`define FE_XLEN 32

// one uncompressed instruction per fetch
`define FE_INSTR_W 32

// ------------------------------
// branch history table
// ------------------------------

// entry count, kept equal to 2**FE_BHT_IDX_W
`define FE_BHT_ENTRIES 16
`define FE_BHT_IDX_W 4
// word aligned fetch, index starts above the byte offset
`define FE_BHT_IDX_LSB 2

`endif

/* fe_pkg.sv */
// shared frontend types; widths follow fe_macros.svh and must not be overridden per instance
`default_nettype none

`include "fe_macros.svh"

package fe_pkg;

  // ------------------------------
  // plain vectors
  // ------------------------------

  // fetch and branch target address
  typedef logic [`FE_XLEN-1:0] addr_t;

  // raw 32-bit instruction word
  typedef logic [`FE_INSTR_W-1:0] instr_t;

  // history table index and counter
  typedef logic [`FE_BHT_IDX_W-1:0] bht_idx_t;
  // upper bit set means predict taken
  typedef logic [1:0] bht_cnt_t;

  // ------------------------------
  // enums
  // ------------------------------

  // control flow class of a fetched word
  typedef enum logic [1:0] {
    CF_NONE,
    CF_BRANCH,
    CF_JUMP
  } cf_kind_e;

  // memory handshake and output states of the fetch FSM
  typedef enum logic [1:0] {
    ST_REQ,
    ST_DROP,
    ST_OUT
  } fetch_state_e;

endpackage

`default_nettype wire

/* instr_scan.sv */
// combinational RV32 scanner; only BRANCH and JAL are recognized, JALR and RVC are left as CF_NONE
`timescale 1ns/1ns
`default_nettype none

`include "fe_macros.svh"

module instr_scan (
  input  fe_pkg::instr_t   instr_i,
  output fe_pkg::cf_kind_e kind_o,
  output fe_pkg::addr_t    imm_o
);

  // major opcodes of interest
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  logic [6:0]    opcode;
  fe_pkg::addr_t imm_b;
  fe_pkg::addr_t imm_j;

  assign opcode = instr_i[6:0];

  // ------------------------------
  // immediate assembly
  // ------------------------------

  // B-type, bit 0 is always zero
  assign imm_b = {{(`FE_XLEN-12){instr_i[31]}},
                  instr_i[7],
                  instr_i[30:25],
                  instr_i[11:8],
                  1'b0};

  // J-type, +-1 MiB range
  assign imm_j = {{(`FE_XLEN-20){instr_i[31]}},
                  instr_i[19:12],
                  instr_i[20],
                  instr_i[30:21],
                  1'b0};

  // ------------------------------
  // classification
  // ------------------------------

  always_comb begin : classify
    kind_o = fe_pkg::CF_NONE;
    imm_o  = '0;
    case (opcode)
      OPC_BRANCH: begin
        kind_o = fe_pkg::CF_BRANCH;
        imm_o  = imm_b;
      end
      OPC_JAL: begin
        kind_o = fe_pkg::CF_JUMP;
        imm_o  = imm_j;
      end
      // everything else falls through sequentially
      default: begin
        kind_o = fe_pkg::CF_NONE;
        imm_o  = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* bht.sv */
// direct mapped 2-bit history table with no tag, so aliasing branches share one counter
`timescale 1ns/1ns
`default_nettype none

`include "fe_macros.svh"

module bht (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          flush_i,
  input  fe_pkg::addr_t lookup_pc_i,
  output logic          pred_valid_o,
  output logic          pred_taken_o,
  input  logic          update_valid_i,
  input  logic          update_branch_i,
  input  fe_pkg::addr_t update_pc_i,
  input  logic          update_taken_i
);

  localparam int unsigned IDX_MSB = `FE_BHT_IDX_LSB + `FE_BHT_IDX_W - 1;

  logic             valid_q [`FE_BHT_ENTRIES];
  fe_pkg::bht_cnt_t cnt_q   [`FE_BHT_ENTRIES];

  fe_pkg::bht_idx_t lookup_idx;
  fe_pkg::bht_idx_t update_idx;
  logic             update_en;
  fe_pkg::bht_cnt_t cnt_cur;
  fe_pkg::bht_cnt_t cnt_next;

  // ------------------------------
  // read port
  // ------------------------------

  assign lookup_idx   = lookup_pc_i[IDX_MSB:`FE_BHT_IDX_LSB];
  assign pred_valid_o = valid_q[lookup_idx];
  // upper counter bit is the direction
  assign pred_taken_o = cnt_q[lookup_idx][1];

  // ------------------------------
  // update port
  // ------------------------------

  assign update_idx = update_pc_i[IDX_MSB:`FE_BHT_IDX_LSB];
  // only resolved conditional branches train the table
  assign update_en  = update_valid_i & update_branch_i;
  assign cnt_cur    = cnt_q[update_idx];

  always_comb begin : next_count
    if (!valid_q[update_idx]) begin
      // first sighting starts weakly in the resolved direction
      cnt_next = update_taken_i ? 2'd2 : 2'd1;
    end else if (update_taken_i) begin
      cnt_next = (cnt_cur == 2'd3) ? cnt_cur : cnt_cur + 2'd1;
    end else begin
      cnt_next = (cnt_cur == 2'd0) ? cnt_cur : cnt_cur - 2'd1;
    end
  end

  // valid bits, flush wins over a same-cycle update
  always_ff @(posedge clk_i or negedge rst_ni) begin : valid_regs
    if (!rst_ni) begin
      for (int i = 0; i < `FE_BHT_ENTRIES; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (flush_i) begin
      for (int i = 0; i < `FE_BHT_ENTRIES; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (update_en) begin
      valid_q[update_idx] <= 1'b1;
    end
  end

  // counter storage, meaningless while the valid bit is low
  always_ff @(posedge clk_i) begin : cnt_regs
    if (update_en) begin
      cnt_q[update_idx] <= cnt_next;
    end
  end

endmodule

`default_nettype wire

/* fetch_ctrl.sv */
// one fetch in flight over four-phase req/ack; redirect inputs must be single-cycle pulses
`timescale 1ns/1ns
`default_nettype none

`include "fe_macros.svh"

module fetch_ctrl (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  fe_pkg::addr_t    boot_addr_i,
  output logic             mem_req_o,
  output fe_pkg::addr_t    mem_addr_o,
  input  logic             mem_ack_i,
  input  fe_pkg::instr_t   mem_rdata_i,
  output fe_pkg::addr_t    fetch_pc_o,
  output fe_pkg::instr_t   fetch_instr_o,
  input  fe_pkg::cf_kind_e scan_kind_i,
  input  fe_pkg::addr_t    scan_imm_i,
  input  logic             bht_valid_i,
  input  logic             bht_taken_i,
  input  logic             ex_valid_i,
  input  fe_pkg::addr_t    trap_vector_i,
  input  logic             eret_i,
  input  fe_pkg::addr_t    epc_i,
  input  logic             resolve_valid_i,
  input  logic             resolve_mispredict_i,
  input  fe_pkg::addr_t    resolve_target_i,
  output logic             entry_valid_o,
  output fe_pkg::addr_t    entry_pc_o,
  output fe_pkg::instr_t   entry_instr_o,
  output logic             entry_pred_taken_o,
  output fe_pkg::addr_t    entry_pred_target_o,
  input  logic             entry_ready_i
);

  fe_pkg::fetch_state_e state_q, state_d;
  fe_pkg::addr_t        pc_q, pc_d;
  // address held stable while req is high
  fe_pkg::addr_t        addr_q;
  // captured word, doubles as the output register
  fe_pkg::addr_t        fetch_pc_q;
  fe_pkg::instr_t       fetch_instr_q;

  logic load_q;
  logic stale_q;
  logic valid_q;
  logic first_q;
  logic taken_q;

  logic mispredict;
  logic redirect;
  logic capture;
  logic launch;
  logic pending;
  logic pred_taken;
  fe_pkg::addr_t jump_target;
  fe_pkg::addr_t seq_target;

  assign mispredict = resolve_valid_i & resolve_mispredict_i;
  assign redirect   = ex_valid_i | eret_i | mispredict;
  assign capture    = (state_q == fe_pkg::ST_REQ) & mem_ack_i;
  // entry still owed to decode after this edge
  assign pending    = valid_q & ~entry_ready_i & ~redirect;

  // ------------------------------
  // prediction
  // ------------------------------

  assign fetch_pc_o    = fetch_pc_q;
  assign fetch_instr_o = fetch_instr_q;

  always_comb begin : predict
    case (scan_kind_i)
      fe_pkg::CF_JUMP:   pred_taken = 1'b1;
      // dynamic if trained, else backward taken / forward not taken
      fe_pkg::CF_BRANCH: pred_taken = bht_valid_i ? bht_taken_i : scan_imm_i[`FE_XLEN-1];
      default:           pred_taken = 1'b0;
    endcase
  end

  assign jump_target = fetch_pc_q + scan_imm_i;
  assign seq_target  = fetch_pc_q + fe_pkg::addr_t'(4);

  // table may retrain while decode stalls, so direction is frozen after the first cycle
  assign entry_pred_taken_o  = first_q ? pred_taken : taken_q;
  assign entry_pred_target_o = entry_pred_taken_o ? jump_target : seq_target;

  // a redirect withdraws the entry in the same cycle
  assign entry_valid_o = valid_q & ~redirect;
  assign entry_pc_o    = fetch_pc_q;
  assign entry_instr_o = fetch_instr_q;

  // ------------------------------
  // next PC, lowest priority first
  // ------------------------------

  always_comb begin : next_pc
    pc_d = pc_q;
    if (load_q) begin
      pc_d = boot_addr_i;
    end
    if (first_q) begin
      pc_d = entry_pred_target_o;
    end
    if (mispredict) begin
      pc_d = resolve_target_i;
    end
    if (eret_i) begin
      pc_d = epc_i;
    end
    if (ex_valid_i) begin
      pc_d = trap_vector_i;
    end
  end

  // ------------------------------
  // fetch FSM
  // ------------------------------

  assign mem_req_o  = (state_q == fe_pkg::ST_REQ);
  assign mem_addr_o = addr_q;

  always_comb begin : fsm
    state_d = state_q;
    launch  = 1'b0;
    case (state_q)
      fe_pkg::ST_REQ: begin
        if (mem_ack_i) begin
          state_d = fe_pkg::ST_DROP;
        end
      end
      fe_pkg::ST_DROP: begin
        // req may only rise again once ack is seen low
        if (!mem_ack_i) begin
          if (pending) begin
            state_d = fe_pkg::ST_OUT;
          end else begin
            state_d = fe_pkg::ST_REQ;
            launch  = 1'b1;
          end
        end
      end
      fe_pkg::ST_OUT: begin
        if (!pending) begin
          state_d = fe_pkg::ST_REQ;
          launch  = 1'b1;
        end
      end
      default: state_d = fe_pkg::ST_DROP;
    endcase
  end

  // reset parks in ST_DROP with ack low, so the boot fetch launches right away
  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
    if (!rst_ni) begin
      state_q <= fe_pkg::ST_DROP;
      pc_q    <= '0;
      load_q  <= 1'b1;
      stale_q <= 1'b0;
      valid_q <= 1'b0;
      first_q <= 1'b0;
      taken_q <= 1'b0;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
      load_q  <= 1'b0;
      first_q <= 1'b0;
      if (first_q) begin
        taken_q <= pred_taken;
      end
      if (redirect || entry_ready_i) begin
        valid_q <= 1'b0;
      end
      if (capture) begin
        // stale words finish the handshake but never reach decode
        stale_q <= 1'b0;
        valid_q <= ~stale_q & ~redirect;
        first_q <= ~stale_q & ~redirect;
      end else if (redirect && state_q == fe_pkg::ST_REQ) begin
        stale_q <= 1'b1;
      end
    end
  end

  // payload registers
  always_ff @(posedge clk_i) begin : data_regs
    if (launch) begin
      addr_q <= pc_d;
    end
    if (capture) begin
      fetch_pc_q    <= addr_q;
      fetch_instr_q <= mem_rdata_i;
    end
  end

endmodule

`default_nettype wire

/* fetch_frontend.sv */
// top of the fetch frontend; boot_addr_i must be stable from reset release until the first ack
`timescale 1ns/1ns
`default_nettype none

module fetch_frontend (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  fe_pkg::addr_t  boot_addr_i,
  input  logic           flush_bp_i,
  // instruction memory, four-phase req/ack
  output logic           mem_req_o,
  output fe_pkg::addr_t  mem_addr_o,
  input  logic           mem_ack_i,
  input  fe_pkg::instr_t mem_rdata_i,
  // decode, valid/ready
  output logic           entry_valid_o,
  output fe_pkg::addr_t  entry_pc_o,
  output fe_pkg::instr_t entry_instr_o,
  output logic           entry_pred_taken_o,
  output fe_pkg::addr_t  entry_pred_target_o,
  input  logic           entry_ready_i,
  // execute resolve pulses
  input  logic           resolve_valid_i,
  input  logic           resolve_branch_i,
  input  fe_pkg::addr_t  resolve_pc_i,
  input  logic           resolve_taken_i,
  input  logic           resolve_mispredict_i,
  input  fe_pkg::addr_t  resolve_target_i,
  // trap and return redirects
  input  logic           ex_valid_i,
  input  fe_pkg::addr_t  trap_vector_i,
  input  logic           eret_i,
  input  fe_pkg::addr_t  epc_i
);

  // captured word and its address, shared by scanner and table
  fe_pkg::addr_t    fetch_pc;
  fe_pkg::instr_t   fetch_instr;
  fe_pkg::cf_kind_e scan_kind;
  fe_pkg::addr_t    scan_imm;
  logic             bht_valid;
  logic             bht_taken;

  // ------------------------------
  // predictors
  // ------------------------------

  instr_scan i_instr_scan (
    .instr_i (fetch_instr),
    .kind_o  (scan_kind),
    .imm_o   (scan_imm)
  );

  // trained directly from resolve, independent of redirect handling
  bht i_bht (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_bp_i),
    .lookup_pc_i     (fetch_pc),
    .pred_valid_o    (bht_valid),
    .pred_taken_o    (bht_taken),
    .update_valid_i  (resolve_valid_i),
    .update_branch_i (resolve_branch_i),
    .update_pc_i     (resolve_pc_i),
    .update_taken_i  (resolve_taken_i)
  );

  // ------------------------------
  // controller
  // ------------------------------

  fetch_ctrl i_fetch_ctrl (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .boot_addr_i          (boot_addr_i),
    .mem_req_o            (mem_req_o),
    .mem_addr_o           (mem_addr_o),
    .mem_ack_i            (mem_ack_i),
    .mem_rdata_i          (mem_rdata_i),
    .fetch_pc_o           (fetch_pc),
    .fetch_instr_o        (fetch_instr),
    .scan_kind_i          (scan_kind),
    .scan_imm_i           (scan_imm),
    .bht_valid_i          (bht_valid),
    .bht_taken_i          (bht_taken),
    .ex_valid_i           (ex_valid_i),
    .trap_vector_i        (trap_vector_i),
    .eret_i               (eret_i),
    .epc_i                (epc_i),
    .resolve_valid_i      (resolve_valid_i),
    .resolve_mispredict_i (resolve_mispredict_i),
    .resolve_target_i     (resolve_target_i),
    .entry_valid_o        (entry_valid_o),
    .entry_pc_o           (entry_pc_o),
    .entry_instr_o        (entry_instr_o),
    .entry_pred_taken_o   (entry_pred_taken_o),
    .entry_pred_target_o  (entry_pred_target_o),
    .entry_ready_i        (entry_ready_i)
  );

endmodule

`default_nettype wire

/* tb_imem.sv */
// backs only the first 1 KiB word aligned, so fetch addresses must stay below 32'h400
`timescale 1ns/1ns
`default_nettype none

module tb_imem (
  input  logic        clk_i,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        ack_o,
  output logic [31:0] rdata_o
);

  localparam int unsigned WORDS = 256;

  // written by the testbench top through hierarchy
  logic [31:0] mem [WORDS];

  // ------------------------------
  // default image
  // ------------------------------

  // addi x0, x0, <word index> so every word is unique and never a jump
  initial begin : fill
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = (i << 20) | 32'h0000_0013;
    end
  end

  // ------------------------------
  // four-phase responder
  // ------------------------------

  // outputs change on the falling edge only
  initial begin : responder
    int unsigned delay;
    ack_o   = 1'b0;
    rdata_o = '0;
    forever begin
      @(negedge clk_i);
      if (req_i && !ack_o) begin
        // 0 to 3 extra cycles of latency
        delay = $urandom_range(3, 0);
        repeat (delay) @(negedge clk_i);
        rdata_o = mem[addr_i[9:2]];
        ack_o   = 1'b1;
      end else if (!req_i && ack_o) begin
        // release phase also lags 0 to 3 cycles, data is left as is
        delay = $urandom_range(3, 0);
        repeat (delay) @(negedge clk_i);
        ack_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* tb_fetch_frontend.sv */
// program image is built in place, fetch stays inside a loop at 32'h80 and never leaves 1 KiB
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_frontend;

  // about ten times a normal run
  localparam int unsigned MAX_CYCLES = 3000;

  logic        clk_i;
  logic        rst_ni;
  logic [31:0] boot_addr_i;
  logic        flush_bp_i;
  logic        mem_req_o;
  logic [31:0] mem_addr_o;
  logic        mem_ack_i;
  logic [31:0] mem_rdata_i;
  logic        entry_valid_o;
  logic [31:0] entry_pc_o;
  logic [31:0] entry_instr_o;
  logic        entry_pred_taken_o;
  logic [31:0] entry_pred_target_o;
  logic        entry_ready_i;
  logic        resolve_valid_i;
  logic        resolve_branch_i;
  logic [31:0] resolve_pc_i;
  logic        resolve_taken_i;
  logic        resolve_mispredict_i;
  logic [31:0] resolve_target_i;
  logic        ex_valid_i;
  logic [31:0] trap_vector_i;
  logic        eret_i;
  logic [31:0] epc_i;

  int unsigned err_cnt   = 0;
  int unsigned xfer_cnt  = 0;
  int unsigned cycle_cnt = 0;

  // reference model state
  logic [31:0] exp_pc;
  logic [31:0] exp_instr;
  logic        seen_q;
  logic        entry_rise;
  logic        model_taken, held_taken, exp_taken;
  logic [31:0] model_target, held_target, exp_target;
  logic        tbl_valid [16];
  logic [1:0]  tbl_cnt   [16];

  fetch_frontend i_fetch_frontend (.*);

  tb_imem i_imem (
    .clk_i   (clk_i),
    .req_i   (mem_req_o),
    .addr_i  (mem_addr_o),
    .ack_o   (mem_ack_i),
    .rdata_o (mem_rdata_i)
  );

  initial begin : clock
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  // ------------------------------
  // encoders and predictor model
  // ------------------------------

  function automatic logic [31:0] enc_jal(input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
  endfunction

  // bne x1, x2
  function automatic logic [31:0] enc_bne(input logic [12:0] off);
    return {off[12], off[10:5], 5'd2, 5'd1, 3'b001, off[4:1], off[11], 7'b1100011};
  endfunction

  // {taken, next pc} by the static and table rules
  function automatic logic [32:0] predict_next(input logic [31:0] pc, input logic [31:0] ins);
    logic [31:0] off;
    logic        tk;
    tk  = 1'b0;
    off = '0;
    if (ins[6:0] == 7'b1101111) begin
      off = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      tk  = 1'b1;
    end else if (ins[6:0] == 7'b1100011) begin
      off = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      // trained entry decides, otherwise backward taken
      tk  = tbl_valid[pc[5:2]] ? tbl_cnt[pc[5:2]][1] : off[31];
    end
    return {tk, tk ? pc + off : pc + 32'd4};
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin : table_model
    int idx;
    idx = resolve_pc_i[5:2];
    if (!rst_ni || flush_bp_i) begin
      for (int i = 0; i < 16; i++) begin
        tbl_valid[i] <= 1'b0;
        tbl_cnt[i]   <= 2'd0;
      end
    end else if (resolve_valid_i && resolve_branch_i) begin
      tbl_valid[idx] <= 1'b1;
      if (!tbl_valid[idx]) tbl_cnt[idx] <= resolve_taken_i ? 2'd2 : 2'd1;
      else if (resolve_taken_i && tbl_cnt[idx] != 2'd3) tbl_cnt[idx] <= tbl_cnt[idx] + 2'd1;
      else if (!resolve_taken_i && tbl_cnt[idx] != 2'd0) tbl_cnt[idx] <= tbl_cnt[idx] - 2'd1;
    end
  end

  // word the image holds at the expected pc
  assign exp_instr = i_imem.mem[exp_pc[9:2]];

  // prediction is fixed in the first cycle an entry is shown
  assign entry_rise = entry_valid_o & ~seen_q;

  always_comb begin : expected_pred
    {model_taken, model_target} = predict_next(exp_pc, exp_instr);
    exp_taken  = entry_rise ? model_taken : held_taken;
    exp_target = entry_rise ? model_target : held_target;
  end

  // expected pc of the next entry, redirects first
  always @(posedge clk_i or negedge rst_ni) begin : pc_model
    if (!rst_ni) begin
      exp_pc      <= boot_addr_i;
      seen_q      <= 1'b0;
      held_taken  <= 1'b0;
      held_target <= '0;
    end else begin
      seen_q <= entry_valid_o & ~entry_ready_i;
      if (entry_rise) begin
        held_taken  <= model_taken;
        held_target <= model_target;
      end
      if (entry_valid_o && entry_ready_i) xfer_cnt <= xfer_cnt + 1;
      if (ex_valid_i) exp_pc <= trap_vector_i;
      else if (eret_i) exp_pc <= epc_i;
      else if (resolve_valid_i && resolve_mispredict_i) exp_pc <= resolve_target_i;
      else if (entry_valid_o && entry_ready_i) exp_pc <= exp_target;
    end
  end

  // ------------------------------
  // checks
  // ------------------------------

  a_pc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    entry_valid_o |-> entry_pc_o == exp_pc)
    else begin
      err_cnt++;
      $display("** Error: entry_pc_o = 0x%08h, expected 0x%08h",
               $sampled(entry_pc_o), $sampled(exp_pc));
    end

  a_instr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    entry_valid_o |-> entry_instr_o == exp_instr)
    else begin
      err_cnt++;
      $display("** Error: entry_instr_o = 0x%08h, expected 0x%08h",
               $sampled(entry_instr_o), $sampled(exp_instr));
    end

  a_taken: assert property (@(posedge clk_i) disable iff (!rst_ni)
    entry_valid_o |-> entry_pred_taken_o == exp_taken)
    else begin
      err_cnt++;
      $display("** Error: entry_pred_taken_o = 0x%0h, expected 0x%0h at pc 0x%08h",
               $sampled(entry_pred_taken_o), $sampled(exp_taken), $sampled(entry_pc_o));
    end

  a_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
    entry_valid_o |-> entry_pred_target_o == exp_target)
    else begin
      err_cnt++;
      $display("** Error: entry_pred_target_o = 0x%08h, expected 0x%08h",
               $sampled(entry_pred_target_o), $sampled(exp_target));
    end

  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(entry_valid_o && !entry_ready_i) && entry_valid_o |->
      $stable(entry_pc_o) && $stable(entry_instr_o) &&
      $stable(entry_pred_taken_o) && $stable(entry_pred_target_o))
    else begin
      err_cnt++;
      $display("entry outputs changed while decode stalled, pc now 0x%08h",
               $sampled(entry_pc_o));
    end

  a_req_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(mem_req_o) |-> !$past(mem_ack_i))
    else begin
      err_cnt++;
      $display("mem_req_o rose before mem_ack_i had fallen");
    end

  a_req_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(mem_req_o) |-> !$past(entry_valid_o && !entry_ready_i))
    else begin
      err_cnt++;
      $display("mem_req_o rose while an entry was still pending");
    end

  a_req_drop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && mem_ack_i |=> !mem_req_o)
    else begin
      err_cnt++;
      $display("mem_req_o stayed high after the ack was sampled");
    end

  a_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && $past(mem_req_o) |-> $stable(mem_addr_o))
    else begin
      err_cnt++;
      $display("mem_addr_o changed during a request");
    end

  // ------------------------------
  // stimulus helpers
  // ------------------------------

  task automatic put_word(input logic [31:0] addr, input logic [31:0] data);
    i_imem.mem[addr[9:2]] = data;
  endtask

  // loop at 32'h80 with a forward branch at 32'h84 and a backward one at 32'h90
  task automatic load_program();
    put_word(32'h50, enc_jal(21'h30));
    put_word(32'h84, enc_bne(13'h10));
    put_word(32'h90, enc_bne(-13'sd16));
    put_word(32'h94, enc_jal(-21'sd20));
    put_word(32'h64, enc_jal(21'h1c));
    put_word(32'ha4, enc_jal(-21'sd36));
    put_word(32'hc4, enc_jal(-21'sd68));
  endtask

  // callers sit on a falling edge
  task automatic wait_transfers(input int unsigned n);
    int unsigned goal;
    goal = xfer_cnt + n;
    while (xfer_cnt < goal) @(negedge clk_i);
  endtask

  task automatic pulse_resolve(input logic [31:0] pc, input logic br, input logic tk,
                               input logic mp, input logic [31:0] tgt);
    resolve_valid_i      = 1'b1;
    resolve_pc_i         = pc;
    resolve_branch_i     = br;
    resolve_taken_i      = tk;
    resolve_mispredict_i = mp;
    resolve_target_i     = tgt;
    @(negedge clk_i);
    resolve_valid_i      = 1'b0;
    resolve_mispredict_i = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic pulse_redirect(input logic ex, input logic er);
    ex_valid_i = ex;
    eret_i     = er;
    @(negedge clk_i);
    ex_valid_i = 1'b0;
    eret_i     = 1'b0;
    @(negedge clk_i);
  endtask

  // random stall spans from decode
  initial begin : ready_driver
    int unsigned hold;
    hold = 0;
    @(posedge rst_ni);
    forever begin
      @(negedge clk_i);
      if (hold == 0) begin
        entry_ready_i = ~entry_ready_i;
        hold = entry_ready_i ? $urandom_range(2, 0) : $urandom_range(4, 0);
      end else begin
        hold--;
      end
    end
  end

  // ------------------------------
  // test sequence
  // ------------------------------

  initial begin : stimulus
    void'($urandom(32'h4036cebe));
    rst_ni               = 1'b0;
    boot_addr_i          = 32'h40;
    flush_bp_i           = 1'b0;
    entry_ready_i        = 1'b0;
    resolve_valid_i      = 1'b0;
    resolve_branch_i     = 1'b0;
    resolve_pc_i         = '0;
    resolve_taken_i      = 1'b0;
    resolve_mispredict_i = 1'b0;
    resolve_target_i     = '0;
    ex_valid_i           = 1'b0;
    trap_vector_i        = 32'hc0;
    eret_i               = 1'b0;
    epc_i                = 32'h60;
    @(posedge clk_i);
    load_program();
    @(posedge clk_i);
    @(negedge clk_i);
    rst_ni     = 1'b1;
    flush_bp_i = 1'b1;
    @(negedge clk_i);
    flush_bp_i = 1'b0;
    // boot, straight line, jal and static branch directions
    wait_transfers(14);
    // backward branch trained not taken
    pulse_resolve(32'h90, 1'b1, 1'b0, 1'b0, 32'h0);
    pulse_resolve(32'h90, 1'b1, 1'b0, 1'b0, 32'h0);
    wait_transfers(10);
    // forward branch trained taken
    pulse_resolve(32'h84, 1'b1, 1'b1, 1'b0, 32'h0);
    pulse_resolve(32'h84, 1'b1, 1'b1, 1'b0, 32'h0);
    wait_transfers(10);
    // trap with a fetch in flight, that word goes stale
    while (!mem_req_o) @(negedge clk_i);
    pulse_redirect(1'b1, 1'b0);
    wait_transfers(5);
    // eret drops the entry on offer
    while (!entry_valid_o) @(negedge clk_i);
    pulse_redirect(1'b0, 1'b1);
    wait_transfers(5);
    pulse_resolve(32'h88, 1'b0, 1'b0, 1'b1, 32'ha0);
    wait_transfers(5);
    // trap and eret together, trap vector wins
    pulse_redirect(1'b1, 1'b1);
    wait_transfers(5);
    repeat (2) @(negedge clk_i);
    $display("errors: %0d, transfers: %0d, cycles: %0d", err_cnt, xfer_cnt, cycle_cnt);
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    while (cycle_cnt < MAX_CYCLES) @(posedge clk_i);
    $display("run stopped after %0d cycles without finishing the sequence", cycle_cnt);
    $display("errors: %0d, transfers: %0d, cycles: %0d", err_cnt, xfer_cnt, cycle_cnt);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
fe_pkg.sv
instr_scan.sv
bht.sv
fetch_ctrl.sv
fetch_frontend.sv
tb_imem.sv
tb_fetch_frontend.sv

/* Bender.yml */
package:
  name: fetch_frontend

export_include_dirs:
  - .

sources:
  - files:
      - fe_pkg.sv
      - instr_scan.sv
      - bht.sv
      - fetch_ctrl.sv
      - fetch_frontend.sv
  - target: test
    files:
      - tb_imem.sv
      - tb_fetch_frontend.sv
